// ==== cgra_tile_pkg.sv ====
package cgra_tile_pkg;

	localparam int num_tracks = 4;
	localparam int num_in_sides = 4;
	localparam int num_out_sides = 2;

	localparam int slot_w = 16;
	localparam int tile_w = 16;
	localparam int cb_sel_w = 3;
	localparam int sb_sel_w = 2;

	// Slot 0 is left free so the host can park the address there.
	localparam logic [slot_w-1:0] slot_sb = 16'd7;
	localparam logic [slot_w-1:0] slot_cb0 = 16'd6;
	localparam logic [slot_w-1:0] slot_cb1 = 16'd5;
	localparam logic [slot_w-1:0] slot_clb = 16'd4;

	typedef struct packed {
		logic [slot_w-1:0] slot;     // Upper half.
		logic [tile_w-1:0] tile;     // Lower half.
	} cfg_addr_t;

	typedef logic [num_tracks-1:0] side_tracks_t;

	typedef side_tracks_t [num_in_sides-1:0] in_tracks_t;
	typedef side_tracks_t [num_out_sides-1:0] out_tracks_t;

	// Index is side * num_tracks + track.
	typedef logic [num_out_sides*num_tracks-1:0][sb_sel_w-1:0] sb_cfg_t;

	typedef enum logic [1:0] {
		op_and = 2'd0,
		op_or = 2'd1,
		op_xor = 2'd2,
		op_nand = 2'd3
	} clb_op_t;

	// Route code to input side, skipping the output side itself.
	function automatic int other_side(input int out_side, input int code);
		if (code < out_side) begin
			return code;
		end
		return code + 1;
	endfunction

endpackage

// ==== connect_box.sv ====
`timescale 1ns/1ps

module connect_box (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               config_en,
	input  logic [cgra_tile_pkg::cb_sel_w-1:0] config_data,
	input  logic [2*cgra_tile_pkg::num_tracks-1:0] tracks,
	output logic                               block_out
);

	logic [cgra_tile_pkg::cb_sel_w-1:0] sel_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data;
		end
	end

	// Lower four from the input side, upper four from the output side.
	assign block_out = tracks[sel_q];

	a_sel_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(sel_q)
	) else $error("connect_box select is unknown");

endmodule

// ==== switch_box.sv ====
`timescale 1ns/1ps

module switch_box (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        config_en,
	input  cgra_tile_pkg::sb_cfg_t      config_data,
	input  cgra_tile_pkg::in_tracks_t   in_wire,
	input  logic                        pe_output,
	output cgra_tile_pkg::out_tracks_t  out_wire
);

	cgra_tile_pkg::sb_cfg_t cfg_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;
		end else if (config_en) begin
			cfg_q <= config_data;
		end
	end

	for (genvar s = 0; s < cgra_tile_pkg::num_out_sides; s++) begin : g_side
		for (genvar t = 0; t < cgra_tile_pkg::num_tracks; t++) begin : g_track
			logic [2**cgra_tile_pkg::sb_sel_w-1:0] cand;
			logic [cgra_tile_pkg::sb_sel_w-1:0] sel;

			// Codes 0..2 take the same track from the other sides.
			for (genvar c = 0; c < 2**cgra_tile_pkg::sb_sel_w - 1; c++) begin : g_cand
				assign cand[c] = in_wire[cgra_tile_pkg::other_side(s, c)][t];
			end

			assign cand[2**cgra_tile_pkg::sb_sel_w-1] = pe_output;  // Code 3.

			assign sel = cfg_q[s*cgra_tile_pkg::num_tracks+t];
			assign out_wire[s][t] = cand[sel];
		end
	end

	// Route selects are 2 bits wide, so all codes are legal once known.
	a_cfg_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(cfg_q)
	) else $error("switch_box routing is unknown");

endmodule

// ==== clb.sv ====
`timescale 1ns/1ps

module clb (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   config_enable,
	input  cgra_tile_pkg::clb_op_t config_data,
	input  logic                   in0,
	input  logic                   in1,
	output logic                   out
);

	cgra_tile_pkg::clb_op_t op_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= cgra_tile_pkg::op_and;
		end else if (config_enable) begin
			op_q <= config_data;
		end
	end

	always_comb begin
		case (op_q)
			cgra_tile_pkg::op_and: begin
				out = in0 & in1;
			end
			cgra_tile_pkg::op_or: begin
				out = in0 | in1;
			end
			cgra_tile_pkg::op_xor: begin
				out = in0 ^ in1;
			end
			cgra_tile_pkg::op_nand: begin
				out = ~(in0 & in1);
			end
			default: begin
				out = 1'b0;                  // Unknown op only.
			end
		endcase
	end

	a_op_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(op_q)
	) else $error("clb operation is unknown");

endmodule

// ==== pe_tile.sv ====
`timescale 1ns/1ps

module pe_tile (
	input  logic                                clk,
	input  logic                                arst_n,
	input  cgra_tile_pkg::cfg_addr_t            cfg_addr,
	input  logic [31:0]                         cfg_data,
	input  logic [cgra_tile_pkg::tile_w-1:0]    tile_id,
	input  cgra_tile_pkg::in_tracks_t           in_wire,
	output cgra_tile_pkg::out_tracks_t          out_wire
);

	typedef struct packed {
		logic sb;
		logic cb0;
		logic cb1;
		logic clb;
	} cfg_en_t;

	cfg_en_t cfg_en;
	logic    tile_hit;
	logic    op_0;
	logic    op_1;
	logic    pe_output;

	assign tile_hit = (cfg_addr.tile == tile_id);

	always_comb begin
		cfg_en = '0;
		if (tile_hit) begin
			cfg_en.sb = (cfg_addr.slot == cgra_tile_pkg::slot_sb);
			cfg_en.cb0 = (cfg_addr.slot == cgra_tile_pkg::slot_cb0);
			cfg_en.cb1 = (cfg_addr.slot == cgra_tile_pkg::slot_cb1);
			cfg_en.clb = (cfg_addr.slot == cgra_tile_pkg::slot_clb);
		end
	end

	// Operand A from side 0.
	connect_box cb0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_en   (cfg_en.cb0),
		.config_data (cfg_data[cgra_tile_pkg::cb_sel_w-1:0]),
		.tracks      ({out_wire[0], in_wire[0]}),
		.block_out   (op_0)
	);

	// Operand B from side 1.
	connect_box cb1 (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_en   (cfg_en.cb1),
		.config_data (cfg_data[cgra_tile_pkg::cb_sel_w-1:0]),
		.tracks      ({out_wire[1], in_wire[1]}),
		.block_out   (op_1)
	);

	switch_box sb (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_en   (cfg_en.sb),
		.config_data (cgra_tile_pkg::sb_cfg_t'(cfg_data[$bits(cgra_tile_pkg::sb_cfg_t)-1:0])),
		.in_wire     (in_wire),
		.pe_output   (pe_output),
		.out_wire    (out_wire)
	);

	clb compute_block (
		.clk           (clk),
		.arst_n        (arst_n),
		.config_enable (cfg_en.clb),
		.config_data   (cgra_tile_pkg::clb_op_t'(cfg_data[1:0])),
		.in0           (op_0),
		.in1           (op_1),
		.out           (pe_output)
	);

	// Slots are distinct, so a write never lands in two blocks.
	a_one_enable: assert property (
		@(posedge clk) disable iff (!arst_n)
		$onehot0(cfg_en)
	) else $error("pe_tile raised more than one config enable");

endmodule

// ==== tb_pe_tile.sv ====
`timescale 1ns/1ps

module tb_pe_tile;

	localparam int clk_half = 50;
	localparam int rand_seed = 17601;
	localparam int max_lines = 200;
	localparam int max_cycles = 5000;
	localparam int max_reset_wait = 10;
	localparam logic [15:0] my_tile = 16'h0012;

	logic                       clk = 1'b0;
	logic                       arst_n;
	cgra_tile_pkg::cfg_addr_t   cfg_addr;
	logic [31:0]                cfg_data;
	logic [15:0]                tile_id;
	cgra_tile_pkg::in_tracks_t  in_wire;
	cgra_tile_pkg::out_tracks_t out_wire;

	// Testbench copy of the tile configuration.
	cgra_tile_pkg::sb_cfg_t             rec_sb;
	logic [cgra_tile_pkg::cb_sel_w-1:0] rec_cb0;
	logic [cgra_tile_pkg::cb_sel_w-1:0] rec_cb1;
	cgra_tile_pkg::clb_op_t             rec_op;

	int num_checks;
	int cycle_cnt = 0;

	pe_tile dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.tile_id  (tile_id),
		.in_wire  (in_wire),
		.out_wire (out_wire)
	);

	always #(clk_half) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "tb_pe_tile stopped");
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > max_cycles) begin
			abort_run("The simulation ran past its cycle limit.");
		end
	end

	// Output side 0 reads sides 1, 2, 3; side 1 reads sides 0, 2, 3.
	function automatic logic [1:0] source_side(input int out_side, input logic [1:0] code);
		if (out_side == 1 && code == 2'd0) begin
			return 2'd0;
		end
		return code + 2'd1;
	endfunction

	function automatic cgra_tile_pkg::out_tracks_t model_out(
		input cgra_tile_pkg::in_tracks_t in_v
	);
		cgra_tile_pkg::out_tracks_t res;
		logic [7:0] cand0;
		logic [7:0] cand1;
		logic [1:0] code;
		logic       opa;
		logic       opb;
		logic       pe;
		res = '0;
		for (int s = 0; s < 2; s++) begin
			for (int t = 0; t < cgra_tile_pkg::num_tracks; t++) begin
				code = rec_sb[3'(s * 4 + t)];
				if (code != 2'd3) begin
					res[1'(s)][2'(t)] = in_v[source_side(s, code)][2'(t)];
				end
			end
		end
		// No loop is configured, so operands never read a code 3 track.
		cand0 = {res[0], in_v[0]};
		cand1 = {res[1], in_v[1]};
		opa = cand0[rec_cb0];
		opb = cand1[rec_cb1];
		case (rec_op)
			cgra_tile_pkg::op_and: pe = opa & opb;
			cgra_tile_pkg::op_or: pe = opa | opb;
			cgra_tile_pkg::op_xor: pe = opa ^ opb;
			cgra_tile_pkg::op_nand: pe = ~(opa & opb);
		endcase
		for (int s = 0; s < 2; s++) begin
			for (int t = 0; t < cgra_tile_pkg::num_tracks; t++) begin
				if (rec_sb[3'(s * 4 + t)] == 2'd3) begin
					res[1'(s)][2'(t)] = pe;
				end
			end
		end
		return res;
	endfunction

	task automatic record_config(input logic [15:0] tile, input logic [15:0] slot,
		input logic [31:0] data);
		if (tile == tile_id) begin
			case (slot)
				cgra_tile_pkg::slot_sb: rec_sb = cgra_tile_pkg::sb_cfg_t'(data[15:0]);
				cgra_tile_pkg::slot_cb0: rec_cb0 = data[2:0];
				cgra_tile_pkg::slot_cb1: rec_cb1 = data[2:0];
				cgra_tile_pkg::slot_clb: rec_op = cgra_tile_pkg::clb_op_t'(data[1:0]);
				default: ;
			endcase
		end
	endtask

	task automatic write_config(input logic [15:0] tile, input logic [15:0] slot,
		input logic [31:0] data);
		@(posedge clk);
		cfg_addr <= '{slot: slot, tile: tile};
		cfg_data <= data;
		@(posedge clk);
		cfg_addr <= '{slot: 16'h0000, tile: tile_id};    // Park slot.
		record_config(tile, slot, data);
	endtask

	task automatic check_out_wire(input cgra_tile_pkg::out_tracks_t got,
		input cgra_tile_pkg::out_tracks_t exp, input int line_no);
		num_checks++;
		if (got !== exp) begin
			abort_run($sformatf("Error: time %0t: line %0d: out_wire %h, expected %h",
				$time, line_no, got, exp));
		end
	endtask

	task automatic apply_vector(input cgra_tile_pkg::in_tracks_t v,
		input cgra_tile_pkg::out_tracks_t exp, input int line_no);
		@(posedge clk);
		in_wire <= v;
		#(2 * clk_half - 1);                          // Just before the next edge.
		check_out_wire(out_wire, exp, line_no);
	endtask

	initial begin
		int          fd;
		int          line_no;
		int          n;
		int          count;
		int          wait_cnt;
		string       line;
		logic [7:0]  first;
		logic [63:0] w0;
		logic [63:0] w1;
		logic [15:0] tile;
		logic [15:0] slot;
		logic [31:0] data;
		logic [15:0] in_hex;
		logic [7:0]  exp_hex;
		cgra_tile_pkg::in_tracks_t v;

		arst_n <= 1'b0;
		cfg_addr <= '0;
		cfg_data <= '0;
		tile_id <= my_tile;
		in_wire <= '0;
		rec_sb = '0;
		rec_cb0 = '0;
		rec_cb1 = '0;
		rec_op = cgra_tile_pkg::op_and;
		num_checks = 0;
		void'($urandom(rand_seed));

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		wait_cnt = 0;
		while ($isunknown(out_wire)) begin
			if (wait_cnt == max_reset_wait) begin
				abort_run("out_wire stayed unknown after reset.");
			end
			@(posedge clk);
			wait_cnt++;
		end

		fd = $fopen("pe_tile_tests.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open pe_tile_tests.txt.");
		end
		line_no = 0;
		n = $fgets(line, fd);
		while (n != 0) begin
			line_no++;
			if (line_no > max_lines) begin
				abort_run("The tests file is longer than the line limit.");
			end
			first = line.getc(0);
			if (first == "c") begin
				if ($sscanf(line, "%s %h %h %h", w0, tile, slot, data) != 4) begin
					abort_run($sformatf("Could not parse line %0d of the tests file.", line_no));
				end
				write_config(tile, slot, data);
			end else if (first == "d" && line.substr(2, 7) == "random") begin
				if ($sscanf(line, "%s %s %d", w0, w1, count) != 3 || count < 1 || count > 1000) begin
					abort_run($sformatf("Bad random count on line %0d of the tests file.", line_no));
				end
				for (int i = 0; i < count; i++) begin
					v = cgra_tile_pkg::in_tracks_t'(16'($urandom()));
					apply_vector(v, model_out(v), line_no);
				end
			end else if (first == "d") begin
				if ($sscanf(line, "%s %h %h", w0, in_hex, exp_hex) != 3) begin
					abort_run($sformatf("Could not parse line %0d of the tests file.", line_no));
				end
				apply_vector(cgra_tile_pkg::in_tracks_t'(in_hex),
					cgra_tile_pkg::out_tracks_t'(exp_hex), line_no);
			end else if (first != "#" && first != "\n" && first != "\r" && first != " ") begin
				abort_run($sformatf("Line %0d of the tests file has an unknown kind.", line_no));
			end
			n = $fgets(line, fd);
		end
		$fclose(fd);

		if (num_checks == 0) begin
			abort_run("The tests file held no data vectors.");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// ==== pe_tile_tests.txt ====
# c <tile> <slot> <data>: configuration write, all hex; the DUT is tile 0012.
# d <in_wire> <out_wire>: hex input and expected output, or d random <count>.
# Reset routing: side 0 from side 1, side 1 from side 0.
d 4321 12
d f0a5 5a
# Code 1 on every track: both sides from side 2.
c 0012 7 5555
d 4321 33
d 9c36 cc
# Code 2 on every track: both sides from side 3.
c 0012 7 aaaa
d 4321 44
d 9c36 99
# Mixed codes per track.
c 0012 7 4624
d 3ca5 d8
d c35a 27
# Compute on side 1 track 3, operands from input tracks.
c 0012 7 c000
c 0012 6 1
c 0012 5 2
c 0012 4 0
d 0066 e6
d 0026 62
c 0012 4 1
d 0026 e2
d 0040 84
d 0000 00
c 0012 4 2
d 0066 66
d 0040 84
c 0012 4 3
d 0066 66
d 0026 e2
# Operands from output tracks.
c 0012 6 5
c 0012 5 6
d 0026 62
d 0020 82
c 0012 4 2
d 0024 42
d 0004 c0
# Writes to another tile or to the park slot.
c 0013 4 0
c 0012 0 ffff
d 0024 42
c 0013 7 0000
d 0004 c0
d random 24
# Compute also on side 0 track 0.
c 0012 7 4627
d random 24

// ==== cgra_tile.f ====
cgra_tile_pkg.sv
connect_box.sv
switch_box.sv
clb.sv
pe_tile.sv
tb_pe_tile.sv

// ==== Makefile ====
# Verilator build and run of the pe_tile testbench.

VERILATOR ?= verilator
TOP       ?= tb_pe_tile
FILELIST  ?= cgra_tile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
